// ==== source/mm_config.svh ====
// ================================================
// Matrix-multiply engine sizes
// Array geometry and datapath widths
// ================================================

`ifndef MM_CONFIG_SVH
`define MM_CONFIG_SVH

// Multiply-accumulate elements per row
`define MM_HEIGHT 4
// Number of parallel rows
`define MM_WIDTH 4

// Signed operand width
`define MM_DATA_W 8
// Signed accumulator and result width, wraps on overflow
`define MM_ACC_W 24

// Step count width, a count of 0 runs one step
`define MM_STEP_W 8

`endif

// ==== source/mm_pkg.sv ====
// ================================================
// Matrix-multiply engine types
// Operand bundles, engine control bus, job states
// ================================================

`include "mm_config.svh"

package mm_pkg;

  // Scalar element types
  typedef logic signed [`MM_DATA_W-1:0] operand_t;
  typedef logic signed [`MM_ACC_W-1:0]  acc_t;

  // Weights of one step, shared by all rows
  typedef struct packed {
    operand_t [`MM_HEIGHT-1:0] w;
  } w_vec_t;

  // X operands seen by a single row
  typedef struct packed {
    operand_t [`MM_HEIGHT-1:0] x;
  } x_row_t;

  // Full X block of one step
  typedef struct packed {
    x_row_t [`MM_WIDTH-1:0] row;
  } x_block_t;

  // One accumulator per row, bias or result
  typedef struct packed {
    acc_t [`MM_WIDTH-1:0] z;
  } z_vec_t;

  // Control bus from the FSM to the array
  typedef struct packed {
    logic step_en;
    logic accumulate;
  } ctrl_engine_t;

  typedef enum logic [1:0] {
    MM_IDLE,
    MM_RUN,
    MM_DONE
  } mm_state_e;

endpackage : mm_pkg

// ==== source/mm_row.sv ====
// ================================================
// Engine row
// Dot product of one X slice with the weights plus
// an addend, held in the row result register
// ================================================

`timescale 1ns/10ps

`include "mm_config.svh"

module mm_row
  import mm_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  x_row_t                      x_row_i,
  input  w_vec_t                      w_vec_i,
  input  logic signed [`MM_ACC_W-1:0] addend_i,
  input  logic                        step_en_i,
  output logic signed [`MM_ACC_W-1:0] z_o
);

  // Full precision products, one per element
  logic signed [2*`MM_DATA_W-1:0] prod [`MM_HEIGHT];
  logic signed [`MM_ACC_W-1:0]    sum;
  logic signed [`MM_ACC_W-1:0]    z_q;

  always_comb begin
    sum = addend_i;
    for (int i = 0; i < `MM_HEIGHT; i++) begin
      prod[i] = x_row_i.x[i] * w_vec_i.w[i];
      // Sign extend each product to accumulator width
      sum = sum + {{(`MM_ACC_W - 2*`MM_DATA_W){prod[i][2*`MM_DATA_W-1]}}, prod[i]};
    end
  end

  // Result register, updated once per accepted step
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      z_q <= '0;
    end else if (step_en_i) begin
      z_q <= sum;
    end
  end

  assign z_o = z_q;

endmodule : mm_row

// ==== source/mm_engine.sv ====
// ================================================
// Engine array
// WIDTH parallel rows with bias or partial result
// feedback selected per row
// ================================================

`timescale 1ns/10ps

`include "mm_config.svh"

module mm_engine
  import mm_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  x_block_t     x_i,
  input  w_vec_t       w_i,
  input  z_vec_t       bias_i,
  input  ctrl_engine_t ctrl_engine_i,
  output z_vec_t       z_o
);

  acc_t [`MM_WIDTH-1:0] row_z;
  acc_t [`MM_WIDTH-1:0] addend;

  for (genvar index = 0; index < `MM_WIDTH; index++) begin : gen_rows

    // Partial result goes back in on later steps of a job
    always_comb begin
      if (ctrl_engine_i.accumulate) begin
        addend[index] = row_z[index];
      end else begin
        addend[index] = bias_i.z[index];
      end
    end

    // Weights broadcast, X sliced per row
    mm_row i_row (
      .clk_i     ( clk_i                 ),
      .reset_i   ( reset_i               ),
      .x_row_i   ( x_i.row[index]        ),
      .w_vec_i   ( w_i                   ),
      .addend_i  ( addend[index]         ),
      .step_en_i ( ctrl_engine_i.step_en ),
      .z_o       ( row_z[index]          )
    );

  end

  assign z_o.z = row_z;

endmodule : mm_engine

// ==== source/mm_step_counter.sv ====
// ================================================
// Step counter
// Counts accepted steps and flags first and last
// ================================================

`timescale 1ns/10ps

`include "mm_config.svh"

module mm_step_counter (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clear_i,
  input  logic [`MM_STEP_W-1:0] k_steps_i,
  input  logic                  count_en_i,
  output logic                  first_step_o,
  output logic                  last_step_o
);

  logic [`MM_STEP_W-1:0] count_q;
  logic [`MM_STEP_W-1:0] target_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q  <= '0;
      target_q <= '0;
    end else if (clear_i) begin
      count_q <= '0;
      // Zero steps still runs one
      if (k_steps_i == '0) begin
        target_q <= `MM_STEP_W'(1);
      end else begin
        target_q <= k_steps_i;
      end
    end else if (count_en_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign first_step_o = (count_q == '0);
  assign last_step_o  = (count_q == target_q - 1'b1);

endmodule : mm_step_counter

// ==== source/mm_ctrl_fsm.sv ====
// ================================================
// Job control FSM
// Sequences start, steps and done for the array
// ================================================

`timescale 1ns/10ps

module mm_ctrl_fsm
  import mm_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         start_i,
  input  logic         step_valid_i,
  input  logic         first_step_i,
  input  logic         last_step_i,
  output logic         clear_o,
  output logic         count_en_o,
  output ctrl_engine_t ctrl_engine_o,
  output logic         busy_o,
  output logic         done_o
);

  mm_state_e state_q;
  mm_state_e state_d;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= MM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d       = state_q;
    clear_o       = 1'b0;
    count_en_o    = 1'b0;
    ctrl_engine_o = '0;

    case (state_q)
      MM_IDLE: begin
        // Load target and zero count on a new job
        if (start_i) begin
          clear_o = 1'b1;
          state_d = MM_RUN;
        end
      end

      MM_RUN: begin
        count_en_o               = step_valid_i;
        ctrl_engine_o.step_en    = step_valid_i;
        // Bias only on the first step of the job
        ctrl_engine_o.accumulate = ~first_step_i;
        if (step_valid_i && last_step_i) begin
          state_d = MM_DONE;
        end
      end

      // One cycle to flag completion
      MM_DONE: begin
        state_d = MM_IDLE;
      end

      default: begin
        state_d = MM_IDLE;
      end
    endcase
  end

  assign busy_o = (state_q == MM_RUN);
  assign done_o = (state_q == MM_DONE);

endmodule : mm_ctrl_fsm

// ==== source/mm_top.sv ====
// ================================================
// Matrix-multiply engine top level
// Control FSM, step counter and row array
// ================================================

`timescale 1ns/10ps

`include "mm_config.svh"

module mm_top
  import mm_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Job start
  input  logic                  start_i,
  input  logic [`MM_STEP_W-1:0] k_steps_i,
  // Held stable for the whole job
  input  z_vec_t                bias_i,
  // Step operands
  input  logic                  step_valid_i,
  input  x_block_t              x_i,
  input  w_vec_t                w_i,
  // Result and status
  output z_vec_t                z_o,
  output logic                  busy_o,
  output logic                  done_o
);

  ctrl_engine_t ctrl_engine;
  logic         clear;
  logic         count_en;
  logic         first_step;
  logic         last_step;

  mm_ctrl_fsm i_ctrl_fsm (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .start_i       ( start_i      ),
    .step_valid_i  ( step_valid_i ),
    .first_step_i  ( first_step   ),
    .last_step_i   ( last_step    ),
    .clear_o       ( clear        ),
    .count_en_o    ( count_en     ),
    .ctrl_engine_o ( ctrl_engine  ),
    .busy_o        ( busy_o       ),
    .done_o        ( done_o       )
  );

  mm_step_counter i_step_counter (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .clear_i      ( clear      ),
    .k_steps_i    ( k_steps_i  ),
    .count_en_i   ( count_en   ),
    .first_step_o ( first_step ),
    .last_step_o  ( last_step  )
  );

  mm_engine i_engine (
    .clk_i         ( clk_i       ),
    .reset_i       ( reset_i     ),
    .x_i           ( x_i         ),
    .w_i           ( w_i         ),
    .bias_i        ( bias_i      ),
    .ctrl_engine_i ( ctrl_engine ),
    .z_o           ( z_o         )
  );

endmodule : mm_top

// ==== testbench/mm_tb.sv ====
// ==================================================
// Matrix-multiply engine testbench
// Replays trace jobs on the DUT and checks results
// ==================================================

`timescale 1ns/10ps

`include "mm_config.svh"

module mm_tb
  import mm_pkg::*;
();

  localparam int MAX_STEPS    = 16;
  localparam int DONE_TIMEOUT = 20;

  logic                  clk_i;
  logic                  reset_i;
  logic                  start_i;
  logic [`MM_STEP_W-1:0] k_steps_i;
  z_vec_t                bias_i;
  logic                  step_valid_i;
  x_block_t              x_i;
  w_vec_t                w_i;
  z_vec_t                z_o;
  logic                  busy_o;
  logic                  done_o;

  integer seed = 70595;
  int     job_index = 0;
  int     fd;
  z_vec_t held_z;

  // Job currently loaded from the trace
  logic [`MM_STEP_W-1:0] job_k;
  z_vec_t                job_bias;
  z_vec_t                job_expect;
  int                    job_steps;
  x_block_t              step_x [MAX_STEPS];
  w_vec_t                step_w [MAX_STEPS];

  mm_top i_mm_top (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .start_i      ( start_i      ),
    .k_steps_i    ( k_steps_i    ),
    .bias_i       ( bias_i       ),
    .step_valid_i ( step_valid_i ),
    .x_i          ( x_i          ),
    .w_i          ( w_i          ),
    .z_o          ( z_o          ),
    .busy_o       ( busy_o       ),
    .done_o       ( done_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAIL: %s is 0x%0h, expected 0x%0h (job %0d)", name, got, exp, job_index);
      stop_on_failure();
    end
  endtask

  task automatic trace_error(input string what);
    $display("Trace file problem in job %0d: %s", job_index, what);
    stop_on_failure();
  endtask

  // Reads the next record tag and skips lines that start with a lone #
  task automatic read_tag(output logic [63:0] tag, output bit found);
    int code;
    int ch;
    bit searching;
    found     = 1'b0;
    searching = 1'b1;
    while (searching) begin
      tag  = '0;
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        searching = 1'b0;
      end else if (tag == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        found     = 1'b1;
        searching = 1'b0;
      end
    end
  endtask

  task automatic read_hex(output logic [31:0] value);
    int code;
    code = $fscanf(fd, "%h", value);
    if (code != 1) begin
      trace_error("missing or bad hex field");
    end
  endtask

  task automatic read_job(output bit found);
    logic [63:0] tag;
    logic [31:0] value;
    bit          more;
    read_tag(tag, found);
    if (found) begin
      if (tag != "job") begin
        trace_error("expected a job line");
      end
      read_hex(value);
      job_k = value[`MM_STEP_W-1:0];
      for (int r = 0; r < `MM_WIDTH; r++) begin
        read_hex(value);
        job_bias.z[r] = value[`MM_ACC_W-1:0];
      end
      // A count of zero still runs one step
      job_steps = (job_k == '0) ? 1 : int'(job_k);
      if (job_steps > MAX_STEPS) begin
        trace_error("too many steps");
      end
      for (int s = 0; s < job_steps; s++) begin
        read_tag(tag, more);
        if (!more || tag != "step") begin
          trace_error("expected a step line");
        end
        for (int r = 0; r < `MM_WIDTH; r++) begin
          for (int e = 0; e < `MM_HEIGHT; e++) begin
            read_hex(value);
            step_x[s].row[r].x[e] = value[7:0];
          end
        end
        for (int e = 0; e < `MM_HEIGHT; e++) begin
          read_hex(value);
          step_w[s].w[e] = value[7:0];
        end
      end
      read_tag(tag, more);
      if (!more || tag != "expect") begin
        trace_error("expected an expect line");
      end
      for (int r = 0; r < `MM_WIDTH; r++) begin
        read_hex(value);
        job_expect.z[r] = value[`MM_ACC_W-1:0];
      end
    end
  endtask

  // Idle cycles between jobs with stray strobes and garbage operands
  task automatic idle_cycles();
    int gap;
    gap = {$random(seed)} % 4;
    repeat (gap) begin
      @(posedge clk_i);
      step_valid_i <= ({$random(seed)} % 2 == 1);
      x_i          <= {$random(seed), $random(seed), $random(seed), $random(seed)};
      w_i          <= $random(seed);
      @(negedge clk_i);
      check_value("busy_o", busy_o, 1'b0);
      check_value("done_o", done_o, 1'b0);
      check_value("z_o", z_o, held_z);
    end
  endtask

  task automatic wait_for_done(output int cycles);
    cycles = 1;
    @(negedge clk_i);
    while (!done_o && cycles < DONE_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done_o) begin
      $display("Timeout: done_o never rose after the last step of job %0d", job_index);
      stop_on_failure();
    end
  endtask

  task automatic run_job();
    int gap;
    int cycles;
    @(posedge clk_i);
    step_valid_i <= 1'b0;
    start_i      <= 1'b1;
    k_steps_i    <= job_k;
    bias_i       <= job_bias;
    @(negedge clk_i);
    check_value("done_o", done_o, 1'b0);
    check_value("busy_o", busy_o, 1'b0);
    check_value("z_o", z_o, held_z);
    @(posedge clk_i);
    start_i <= 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b1);
    for (int s = 0; s < job_steps; s++) begin
      gap = {$random(seed)} % 4;
      repeat (gap) begin
        @(posedge clk_i);
        step_valid_i <= 1'b0;
        @(negedge clk_i);
        check_value("busy_o", busy_o, 1'b1);
        check_value("done_o", done_o, 1'b0);
      end
      @(posedge clk_i);
      step_valid_i <= 1'b1;
      x_i          <= step_x[s];
      w_i          <= step_w[s];
      @(negedge clk_i);
      check_value("busy_o", busy_o, 1'b1);
      check_value("done_o", done_o, 1'b0);
    end
    // This edge accepts the last step
    @(posedge clk_i);
    step_valid_i <= 1'b0;
    wait_for_done(cycles);
    check_value("done_o latency", cycles, 1);
    check_value("busy_o", busy_o, 1'b0);
    check_value("z_o", z_o, job_expect);
    held_z = job_expect;
  endtask

  initial begin
    bit more;
    reset_i      <= 1'b1;
    start_i      <= 1'b0;
    k_steps_i    <= '0;
    bias_i       <= '0;
    step_valid_i <= 1'b0;
    x_i          <= '0;
    w_i          <= '0;
    held_z = '0;
    fd = $fopen("testbench/mm_trace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file testbench/mm_trace.txt");
      stop_on_failure();
    end
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("busy_o", busy_o, 1'b0);
    check_value("done_o", done_o, 1'b0);
    check_value("z_o", z_o, '0);
    more = 1'b1;
    while (more) begin
      read_job(more);
      if (more) begin
        idle_cycles();
        run_job();
        job_index++;
      end
    end
    $fclose(fd);
    if (job_index > 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      $display("No job was read from the trace file");
      stop_on_failure();
    end
  end

endmodule : mm_tb

// ==== testbench/mm_trace.txt ====
# job: step count, bias of rows 0..3
# step: X of row 0 elements 0..3, then rows 1..3, then W elements 0..3
# expect: result of rows 0..3; all fields hex, two's complement

# Single step, mixed signs
job 01 000010 000020 000030 000040
step 01 02 03 04 05 06 07 08 FF FE FD FC 10 00 00 00 01 01 02 02
expect 000021 000049 00001F 000050

# Count of zero runs one step, results wrap at 24 bits
job 00 FFFFFF 000000 7FFFFF 800000
step 80 80 80 80 7F 7F 7F 7F 81 00 00 00 7F 00 00 00 80 80 80 80
expect 00FFFF FF0200 803F7F 7FC080

# Three steps with accumulation
job 03 000100 FFFF00 000000 000005
step 01 01 01 01 02 00 00 00 FF 00 00 00 00 00 00 00 03 04 05 06
step 00 00 00 0A 01 01 01 01 00 FF 00 00 02 02 02 02 01 02 03 FF
step 7F 7F 00 00 00 00 00 00 10 10 10 10 FE 00 00 00 7F 7F 7F 7F
expect 007F0A FFFF0B 001FBB FFFF11

# Back to back job, starts again from its own bias
job 02 000001 000002 000003 000004
step 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
step 02 02 02 02 00 00 00 00 FF FF FF FF 01 00 00 00 01 01 01 01
expect 00000D 000006 000003 000009

# Overflow across steps
job 02 7FFF00 000000 000000 000000
step 7F 7F 7F 7F 80 80 80 80 00 00 00 00 00 00 00 00 7F 7F 7F 7F
step 7F 7F 7F 7F 80 80 80 80 00 00 00 00 00 00 00 00 7F 7F 7F 7F
expect 81F708 FE0400 000000 000000

// ==== flist.f ====
+incdir+source
source/mm_pkg.sv
source/mm_row.sv
source/mm_engine.sv
source/mm_step_counter.sv
source/mm_ctrl_fsm.sv
source/mm_top.sv
testbench/mm_tb.sv

// ==== Makefile ====
# Verilator build and run for the matrix-multiply engine

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal --timescale 1ns/10ps
TOP       ?= mm_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
